// File: rtl/msu_pkg.sv
// Audio stream types: PCM sample, track volume, mix sum, scaled product, stream constants
`default_nettype none

package msu_pkg;

	// ====================
	// Stream constants
	// ====================

	// One PCM channel sample on the host stream
	localparam int SAMPLE_W = 16;

	// Leading words of every track that carry no audio
	localparam int HEADER_WORDS = 4;

	// ====================
	// Data types
	// ====================

	typedef logic signed [SAMPLE_W-1:0] sample_t;

	// 255 is close to unity gain
	typedef logic [7:0] volume_t;

	// Main plus stream, one guard bit before the halving
	typedef logic signed [SAMPLE_W:0] mix_t;

	// Sample times volume, upper 16 bits are the scaled sample
	typedef logic signed [23:0] scaled_t;

endpackage

`default_nettype wire

// File: rtl/sample_fifo.sv
// Single-clock circular FIFO for stream samples, with one-cycle flush
`timescale 1ns/1ps
`default_nettype none

module sample_fifo #(
	parameter int FIFO_DEPTH = 8
) (
	input  logic             clk_sys,
	input  logic             RESET,
	input  logic             flush,
	input  logic             push,
	input  msu_pkg::sample_t push_data,
	input  logic             pop,
	output msu_pkg::sample_t pop_data,
	output logic             empty,
	output logic             full
);

	// FIFO_DEPTH is a power of two so the pointers wrap on their own
	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam int CNT_W = PTR_W + 1;

	msu_pkg::sample_t mem [FIFO_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	// Sample storage
	always_ff @(posedge clk_sys) begin
		if (push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	// Pointers and occupancy
	always_ff @(posedge clk_sys) begin
		if (RESET || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Oldest entry is always on the read port
	assign pop_data = mem[rd_ptr];

	assign empty = (count == '0);
	assign full  = (count == CNT_W'(FIFO_DEPTH));

endmodule

`default_nettype wire

// File: rtl/msu_stream.sv
// Stream front end: track header drop, sample FIFO writes and credit return to the host
`timescale 1ns/1ps
`default_nettype none

module msu_stream #(
	parameter int FIFO_DEPTH = 8
) (
	input  logic             clk_sys,
	input  logic             RESET,
	input  logic             word_valid,
	input  msu_pkg::sample_t word_data,
	input  logic             track_start,
	input  logic             pop,
	output msu_pkg::sample_t fifo_data,
	output logic             fifo_empty,
	output logic             credit_return
);

	localparam int HDR_W = $clog2(msu_pkg::HEADER_WORDS + 1);

	logic [HDR_W-1:0] hdr_cnt;
	logic             hdr_done;
	logic             drop;
	logic             push;
	logic             pop_ok;
	logic             full;
	logic             credit_q;
	logic             pending;
	logic [1:0]       owed;

	// ====================
	// Header skip
	// ====================

	// Counts up to HEADER_WORDS and then sticks until the next track
	assign hdr_done = (hdr_cnt == HDR_W'(msu_pkg::HEADER_WORDS));

	// Words that come with track_start belong to neither track and are ignored
	assign drop   = word_valid && !hdr_done && !track_start;
	assign push   = word_valid && hdr_done && !track_start && !full;
	assign pop_ok = pop && !track_start;

	// ====================
	// Credit return
	// ====================

	// A drop and a pop in one cycle owe two credits, the second goes out next cycle
	assign owed = {1'b0, pending} + {1'b0, drop} + {1'b0, pop_ok};

	always_ff @(posedge clk_sys) begin
		if (RESET || track_start) begin
			hdr_cnt  <= '0;
			credit_q <= 1'b0;
			pending  <= 1'b0;
		end else begin
			if (drop) begin
				hdr_cnt <= hdr_cnt + 1'b1;
			end
			credit_q <= (owed != 2'd0);
			pending  <= owed[1];
		end
	end

	assign credit_return = credit_q;

	sample_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) sample_fifo_i (
		.clk_sys   (clk_sys),
		.RESET     (RESET),
		.flush     (track_start),
		.push      (push),
		.push_data (word_data),
		.pop       (pop),
		.pop_data  (fifo_data),
		.empty     (fifo_empty),
		.full      (full)
	);

endmodule

`default_nettype wire

// File: rtl/sample_pacer.sv
// Sample rate divider issuing ticks that alternate between left and right channel
`timescale 1ns/1ps
`default_nettype none

module sample_pacer #(
	parameter int SAMPLE_DIV = 8
) (
	input  logic clk_sys,
	input  logic RESET,
	input  logic play,
	input  logic track_start,
	output logic sample_tick,
	output logic right_phase
);

	// SAMPLE_DIV of at least two is expected
	localparam int CNT_W = $clog2(SAMPLE_DIV);
	localparam logic [CNT_W-1:0] RELOAD = CNT_W'(SAMPLE_DIV - 1);

	logic [CNT_W-1:0] div_cnt;
	logic             next_right;

	always_ff @(posedge clk_sys) begin
		if (RESET || track_start) begin
			div_cnt     <= RELOAD;
			sample_tick <= 1'b0;
			right_phase <= 1'b0;
			next_right  <= 1'b0;
		end else if (!play) begin
			// Paused, hold at reload so the first tick after play is a full period away
			div_cnt     <= RELOAD;
			sample_tick <= 1'b0;
		end else if (div_cnt == '0) begin
			div_cnt     <= RELOAD;
			sample_tick <= 1'b1;
			right_phase <= next_right;
			next_right  <= !next_right;
		end else begin
			div_cnt     <= div_cnt - 1'b1;
			sample_tick <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: rtl/msu_player.sv
// Sample player: FIFO pops on pacer ticks, left/right pairing, volume scaling, main audio mix
`timescale 1ns/1ps
`default_nettype none

module msu_player (
	input  logic             clk_sys,
	input  logic             RESET,
	input  logic             sample_tick,
	input  logic             right_phase,
	input  msu_pkg::sample_t fifo_data,
	input  logic             fifo_empty,
	input  logic             play,
	input  logic             msu_enable,
	input  msu_pkg::volume_t volume,
	input  msu_pkg::sample_t main_l,
	input  msu_pkg::sample_t main_r,
	output logic             pop,
	output msu_pkg::sample_t audio_l,
	output msu_pkg::sample_t audio_r
);

	msu_pkg::sample_t in_sample;
	msu_pkg::sample_t held_l;
	msu_pkg::sample_t scaled_l;
	msu_pkg::sample_t scaled_r;
	msu_pkg::sample_t next_l;
	msu_pkg::sample_t next_r;
	msu_pkg::sample_t strm_l;
	msu_pkg::sample_t strm_r;
	logic             take_l;
	logic             take_r;

	// ====================
	// Helpers
	// ====================

	// Volume is unsigned, so it gets a zero sign bit before the signed multiply
	function automatic msu_pkg::sample_t scale(
		input msu_pkg::sample_t s,
		input msu_pkg::volume_t v
	);
		msu_pkg::scaled_t p;
		p = msu_pkg::scaled_t'(s * $signed({1'b0, v}));
		return p[23:8];
	endfunction

	// Average of two samples with no overflow
	function automatic msu_pkg::sample_t mix(
		input msu_pkg::sample_t a,
		input msu_pkg::sample_t b
	);
		msu_pkg::mix_t m;
		m = msu_pkg::mix_t'(a) + msu_pkg::mix_t'(b);
		return m[16:1];
	endfunction

	// ====================
	// Sample pickup
	// ====================

	assign pop = sample_tick && !fifo_empty;

	// Underrun plays silence on that channel
	assign in_sample = fifo_empty ? '0 : fifo_data;

	assign take_l = sample_tick && !right_phase;
	assign take_r = sample_tick && right_phase;

	// The pair goes live together on the right tick
	assign next_l = take_r ? scale(held_l, volume) : scaled_l;
	assign next_r = take_r ? scale(in_sample, volume) : scaled_r;

	assign strm_l = play ? next_l : '0;
	assign strm_r = play ? next_r : '0;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			held_l   <= '0;
			scaled_l <= '0;
			scaled_r <= '0;
			audio_l  <= '0;
			audio_r  <= '0;
		end else begin
			if (take_l) begin
				held_l <= in_sample;
			end
			scaled_l <= next_l;
			scaled_r <= next_r;
			audio_l  <= msu_enable ? mix(main_l, strm_l) : main_l;
			audio_r  <= msu_enable ? mix(main_r, strm_r) : main_r;
		end
	end

endmodule

`default_nettype wire

// File: rtl/msu_audio_top.sv
// Audio streaming top level: stream front end, sample pacer and player
`timescale 1ns/1ps
`default_nettype none

module msu_audio_top #(
	parameter int FIFO_DEPTH = 64,
	parameter int SAMPLE_DIV = 512
) (
	input  logic             clk_sys,
	input  logic             RESET,

	// Host stream
	input  logic             word_valid,
	input  msu_pkg::sample_t word_data,
	output logic             credit_return,

	// Control
	input  logic             track_start,
	input  logic             play,
	input  logic             msu_enable,
	input  msu_pkg::volume_t volume,

	// Console audio in, mixed audio out
	input  msu_pkg::sample_t main_l,
	input  msu_pkg::sample_t main_r,
	output msu_pkg::sample_t audio_l,
	output msu_pkg::sample_t audio_r
);

	msu_pkg::sample_t fifo_data;
	logic             fifo_empty;
	logic             pop;
	logic             sample_tick;
	logic             right_phase;

	msu_stream #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) msu_stream_i (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.word_valid    (word_valid),
		.word_data     (word_data),
		.track_start   (track_start),
		.pop           (pop),
		.fifo_data     (fifo_data),
		.fifo_empty    (fifo_empty),
		.credit_return (credit_return)
	);

	sample_pacer #(
		.SAMPLE_DIV(SAMPLE_DIV)
	) sample_pacer_i (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.play        (play),
		.track_start (track_start),
		.sample_tick (sample_tick),
		.right_phase (right_phase)
	);

	msu_player msu_player_i (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.sample_tick (sample_tick),
		.right_phase (right_phase),
		.fifo_data   (fifo_data),
		.fifo_empty  (fifo_empty),
		.play        (play),
		.msu_enable  (msu_enable),
		.volume      (volume),
		.main_l      (main_l),
		.main_r      (main_r),
		.pop         (pop),
		.audio_l     (audio_l),
		.audio_r     (audio_r)
	);

endmodule

`default_nettype wire

// File: test/msu_audio_properties.sv
// Concurrent assertions on the stream front end: FIFO overflow, empty pops, credits on restart
`timescale 1ns/1ps
`default_nettype none

module msu_audio_properties (
	input logic clk_sys,
	input logic RESET,
	input logic word_valid,
	input logic full,
	input logic pop,
	input logic fifo_empty,
	input logic track_start,
	input logic credit_return
);

	// Host credits keep the FIFO from overflowing
	no_write_when_full: assert property (
		@(posedge clk_sys) disable iff (RESET) word_valid |-> !full
	) else $error("stream word arrived while the sample FIFO was full");

	no_pop_when_empty: assert property (
		@(posedge clk_sys) disable iff (RESET) pop |-> !fifo_empty
	) else $error("player popped an empty sample FIFO");

	// Flushed samples never hand a credit back
	no_credit_on_restart: assert property (
		@(posedge clk_sys) disable iff (RESET) track_start |-> !credit_return
	) else $error("credit returned in a track start cycle");

endmodule

bind msu_stream msu_audio_properties msu_audio_properties_i (
	.clk_sys       (clk_sys),
	.RESET         (RESET),
	.word_valid    (word_valid),
	.full          (full),
	.pop           (pop),
	.fifo_empty    (fifo_empty),
	.track_start   (track_start),
	.credit_return (credit_return)
);

`default_nettype wire

// File: test/tb_msu_audio.sv
// Testbench for the audio streaming top level: clock, reset, credit tracking, directed tests
`timescale 1ns/1ps
`default_nettype none

module tb_msu_audio;

	localparam int FIFO_DEPTH = 8;
	localparam int SAMPLE_DIV = 8;
	localparam int WAIT_LIMIT = 200;

	logic             clk_sys;
	logic             RESET;
	logic             word_valid;
	logic             credit_return;
	logic             track_start;
	logic             play;
	logic             msu_enable;
	msu_pkg::volume_t volume;
	msu_pkg::sample_t word_data;
	msu_pkg::sample_t main_l;
	msu_pkg::sample_t main_r;
	msu_pkg::sample_t audio_l;
	msu_pkg::sample_t audio_r;

	integer seed = 32'hd996;
	int     errors = 0;
	int     checks = 0;
	int     words_sent = 0;
	int     credits_returned = 0;
	int     credit_base = FIFO_DEPTH;
	// Scaled stream pair the player should be holding
	int     last_l = 0;
	int     last_r = 0;

	msu_audio_top #(.FIFO_DEPTH(FIFO_DEPTH), .SAMPLE_DIV(SAMPLE_DIV)) msu_audio_top_i (.*);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	always @(negedge clk_sys) begin
		if (credit_return) begin
			credits_returned <= credits_returned + 1;
		end
	end

	// ====================
	// Reference rules
	// ====================

	function automatic int credits_left();
		return credit_base + credits_returned - words_sent;
	endfunction

	function automatic msu_pkg::sample_t random_sample();
		return 16'($random(seed));
	endfunction

	// Upper 16 bits of the 24-bit product
	function automatic int scaled_value(input int s, input int v);
		return (s * v) >>> 8;
	endfunction

	function automatic int averaged(input int main_v, input int strm_v);
		return (main_v + strm_v) >>> 1;
	endfunction

	// ====================
	// Helpers
	// ====================

	task automatic check(input string name, input int expected, input int actual);
		checks++;
		if (expected != actual) begin
			errors++;
			$display("** Error [%s]: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	task automatic stop_on_timeout(input string what);
		$display("Timeout: %s", what);
		$display("tests failed");
		$finish;
	endtask

	task automatic send_word(input msu_pkg::sample_t d);
		int n;
		n = 0;
		while (credits_left() <= 0) begin
			@(posedge clk_sys);
			n++;
			if (n > WAIT_LIMIT) begin
				stop_on_timeout("no credit came back to send the next word");
			end
		end
		@(posedge clk_sys);
		word_valid <= 1'b1;
		word_data  <= d;
		words_sent++;
		@(posedge clk_sys);
		word_valid <= 1'b0;
	endtask

	task automatic wait_credits_full(input string name);
		int n;
		n = 0;
		while (credits_left() != FIFO_DEPTH) begin
			@(posedge clk_sys);
			n++;
			if (n > WAIT_LIMIT) begin
				stop_on_timeout({name, ": not all credits came back"});
			end
		end
	endtask

	task automatic wait_output_change(input string name, input int was_l, input int was_r);
		int n;
		n = 0;
		@(negedge clk_sys);
		while (int'(audio_l) == was_l && int'(audio_r) == was_r) begin
			@(negedge clk_sys);
			n++;
			if (n > WAIT_LIMIT) begin
				stop_on_timeout({name, ": audio outputs never changed"});
			end
		end
	endtask

	// Flush, drop the header words and get every credit back
	task automatic start_track(input string name);
		int ret0;
		@(posedge clk_sys);
		track_start <= 1'b1;
		@(posedge clk_sys);
		track_start <= 1'b0;
		credit_base = FIFO_DEPTH - credits_returned + words_sent;
		ret0 = credits_returned;
		@(negedge clk_sys);
		check(name, 1, int'(msu_audio_top_i.fifo_empty));
		for (int i = 0; i < msu_pkg::HEADER_WORDS; i++) begin
			send_word(random_sample());
		end
		wait_credits_full(name);
		// A doubled or pending credit would still arrive within two cycles
		repeat (2) begin
			@(posedge clk_sys);
		end
		check(name, msu_pkg::HEADER_WORDS, credits_returned - ret0);
		check(name, 1, int'(msu_audio_top_i.fifo_empty));
	endtask

	// ====================
	// Tests
	// ====================

	task automatic pass_through();
		for (int i = 0; i < 8; i++) begin
			@(posedge clk_sys);
			main_l <= random_sample();
			main_r <= random_sample();
			@(posedge clk_sys);
			@(negedge clk_sys);
			check("pass_through", int'(main_l), int'(audio_l));
			check("pass_through", int'(main_r), int'(audio_r));
		end
	endtask

	task automatic header_drop();
		@(posedge clk_sys);
		main_l     <= random_sample();
		main_r     <= random_sample();
		msu_enable <= 1'b0;
		start_track("header_drop");
		check("header_drop", int'(main_l), int'(audio_l));
		check("header_drop", int'(main_r), int'(audio_r));
	endtask

	// Loads pairs with play low, then plays them and checks every output step
	task automatic play_pairs(input string name, input int n_pairs, input int vol,
		input int m_l, input int m_r);
		int exp_l [$];
		int exp_r [$];
		int s_l;
		int s_r;
		int prev_l;
		int prev_r;
		int ret0;
		@(posedge clk_sys);
		volume     <= 8'(vol);
		main_l     <= 16'(m_l);
		main_r     <= 16'(m_r);
		msu_enable <= 1'b1;
		ret0   = credits_returned;
		prev_l = averaged(m_l, last_l);
		prev_r = averaged(m_r, last_r);
		exp_l.push_back(prev_l);
		exp_r.push_back(prev_r);
		for (int i = 0; i < n_pairs; i++) begin
			// Each pair has to move the outputs, or its arrival cannot be seen
			do begin
				s_l = int'(random_sample());
				s_r = int'(random_sample());
			end while (averaged(m_l, scaled_value(s_l, vol)) == prev_l
				&& averaged(m_r, scaled_value(s_r, vol)) == prev_r);
			last_l = scaled_value(s_l, vol);
			last_r = scaled_value(s_r, vol);
			prev_l = averaged(m_l, last_l);
			prev_r = averaged(m_r, last_r);
			exp_l.push_back(prev_l);
			exp_r.push_back(prev_r);
			send_word(16'(s_l));
			send_word(16'(s_r));
		end
		@(posedge clk_sys);
		play <= 1'b1;
		@(posedge clk_sys);
		@(negedge clk_sys);
		for (int i = 0; i <= n_pairs; i++) begin
			if (i > 0) begin
				wait_output_change(name, int'(audio_l), int'(audio_r));
			end
			check(name, exp_l[i], int'(audio_l));
			check(name, exp_r[i], int'(audio_r));
		end
		@(posedge clk_sys);
		play <= 1'b0;
		wait_credits_full(name);
		// A doubled or pending credit would still arrive within two cycles
		repeat (2) begin
			@(posedge clk_sys);
		end
		check(name, 2 * n_pairs, credits_returned - ret0);
	endtask

	task automatic volume_mix();
		int m_l;
		int m_r;
		m_l = int'(random_sample());
		m_r = int'(random_sample());
		play_pairs("volume_mix", 3, 128, m_l, m_r);
		@(posedge clk_sys);
		msu_enable <= 1'b0;
		@(posedge clk_sys);
		@(negedge clk_sys);
		check("volume_mix", m_l, int'(audio_l));
		check("volume_mix", m_r, int'(audio_r));
	endtask

	task automatic underrun();
		@(posedge clk_sys);
		main_l     <= random_sample();
		main_r     <= random_sample();
		msu_enable <= 1'b1;
		play       <= 1'b1;
		// A left and a right tick on the empty FIFO, then the output register
		repeat (2 * SAMPLE_DIV + 2) begin
			@(posedge clk_sys);
		end
		@(negedge clk_sys);
		check("underrun", averaged(int'(main_l), 0), int'(audio_l));
		check("underrun", averaged(int'(main_r), 0), int'(audio_r));
		check("underrun", FIFO_DEPTH, credits_left());
		@(posedge clk_sys);
		play <= 1'b0;
		last_l = 0;
		last_r = 0;
	endtask

	task automatic track_restart();
		// Stale pair from the old track, flushed by the restart
		send_word(random_sample());
		send_word(random_sample());
		start_track("track_restart");
		play_pairs("track_restart", 2, 255, 0, 0);
	endtask

	initial begin
		RESET       <= 1'b1;
		word_valid  <= 1'b0;
		word_data   <= '0;
		track_start <= 1'b0;
		play        <= 1'b0;
		msu_enable  <= 1'b0;
		volume      <= '0;
		main_l      <= '0;
		main_r      <= '0;
		repeat (10) begin
			@(posedge clk_sys);
		end
		RESET <= 1'b0;
		@(negedge clk_sys);
		check("reset", 0, int'(audio_l));
		check("reset", 0, int'(audio_r));
		check("reset", 0, int'(credit_return));
		pass_through();
		header_drop();
		play_pairs("playback", 4, 255, 0, 0);
		volume_mix();
		underrun();
		track_restart();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
rtl/msu_pkg.sv
rtl/sample_fifo.sv
rtl/msu_stream.sv
rtl/sample_pacer.sv
rtl/msu_player.sv
rtl/msu_audio_top.sv
test/msu_audio_properties.sv
test/tb_msu_audio.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_msu_audio -f tb.f -o tb_msu_audio \
	&& ./obj_dir/tb_msu_audio > sim.log 2>&1 \
	|| { echo "Simulation did not build or run"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -qx "all tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
